/* seg_pkg.sv */
`default_nettype none

package seg_pkg;

	localparam int NUM_DIGITS = 8;

	typedef enum logic
	{
		mode_hex   = 1'b0,
		mode_mixed = 1'b1
	} disp_mode_e;

	// one display word, read either as eight hex nibbles or as four glyphs over four nibbles
	typedef union packed
	{
		logic [NUM_DIGITS-1:0][3:0] hex;
		struct packed
		{
			logic [3:0][3:0] glyph;
			logic [3:0][3:0] nib;
		} mixed;
	} disp_word_u;

	// segments are active low, bit 0 is segment a and bit 6 is segment g
	function automatic logic [6:0] hex_segments(input logic [3:0] nibble);
		logic [6:0] seg;
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011;
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001;
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110;
		endcase
		return seg;
	endfunction

	function automatic logic [6:0] glyph_segments(input logic [3:0] code);
		logic [6:0] seg;
		case (code)
			4'd1: seg = 7'b0001011;
			4'd2: seg = 7'b0010010;
			4'd3: seg = 7'b1111001;
			4'd4: seg = 7'b0001001;
			4'd5: seg = 7'b0000110;
			4'd6: seg = 7'b1000111;
			4'd7: seg = 7'b0001100;
			4'd8: seg = 7'b0101111;
			4'd9: seg = 7'b0100011;
			4'd10: seg = 7'b0101011;
			4'd11: seg = 7'b1100011;
			4'd12: seg = 7'b0111111;
			// code 0 and the unused codes 13 to 15 are blank
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire

/* value_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module value_receiver #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  logic                in_valid,
	input  logic [31:0]         in_data,
	input  seg_pkg::disp_mode_e in_mode,
	input  logic                frame_end,
	output logic                credit,
	output seg_pkg::disp_word_u disp_word,
	output seg_pkg::disp_mode_e disp_mode
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [31:0]         word_mem [FIFO_DEPTH];
	seg_pkg::disp_mode_e mode_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push;
	logic pop;

	// the producer only sends while it holds credit, so every valid word fits
	assign push = in_valid;
	// a word only leaves the FIFO at the last cycle of a scan frame
	assign pop  = frame_end && (count != '0);

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			word_mem[wr_ptr] <= in_data;
			mode_mem[wr_ptr] <= in_mode;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
			begin
				if (wr_ptr == PTR_W'(FIFO_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop)
			begin
				if (rd_ptr == PTR_W'(FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credit goes back in the same cycle the new word first shows on the display
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			credit    <= 1'b0;
			disp_word <= '0;
			disp_mode <= seg_pkg::mode_hex;
		end
		else
		begin
			credit <= pop;
			if (pop)
			begin
				disp_word <= word_mem[rd_ptr];
				disp_mode <= mode_mem[rd_ptr];
			end
		end
	end

endmodule

`default_nettype wire

/* scan_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module scan_timer #(
	parameter int DIV_BITS = 17
) (
	input  wire        clk,
	input  wire        rst_n,
	output logic [2:0] digit_sel,
	output logic       frame_end
);

	localparam int CNT_W = DIV_BITS + 3;

	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// each digit stays active for 2**DIV_BITS cycles
	assign digit_sel = div_cnt[CNT_W-1:DIV_BITS];

	// last cycle of digit 7, the counter wraps on the next edge
	assign frame_end = &div_cnt;

endmodule

`default_nettype wire

/* zero_blanker.sv */
`timescale 1ns/1ns
`default_nettype none

module zero_blanker (
	input  seg_pkg::disp_word_u disp_word,
	input  seg_pkg::disp_mode_e disp_mode,
	output logic [7:0]          digit_en
);

	logic seen;

	always_comb
	begin
		digit_en = '0;
		seen     = 1'b0;
		if (disp_mode == seg_pkg::mode_mixed)
		begin
			// glyph digits are always lit, a blank glyph just shows no segments
			digit_en[7:4] = 4'hf;
			for (int k = 3; k >= 0; k--)
			begin
				seen        = seen | (disp_word.mixed.nib[k] != 4'h0);
				digit_en[k] = seen;
			end
		end
		else
		begin
			for (int k = seg_pkg::NUM_DIGITS - 1; k >= 0; k--)
			begin
				seen        = seen | (disp_word.hex[k] != 4'h0);
				digit_en[k] = seen;
			end
		end
		// a zero value still shows one "0"
		digit_en[0] = 1'b1;
	end

endmodule

`default_nettype wire

/* segment_driver.sv */
`timescale 1ns/1ns
`default_nettype none

module segment_driver (
	input  logic [2:0]          digit_sel,
	input  seg_pkg::disp_word_u disp_word,
	input  seg_pkg::disp_mode_e disp_mode,
	input  logic [7:0]          digit_en,
	output logic [6:0]          a_to_g,
	output logic [7:0]          an
);

	logic       glyph_sel;
	logic [3:0] code;

	// only the upper half of a mixed word holds glyph codes
	assign glyph_sel = (disp_mode == seg_pkg::mode_mixed) && digit_sel[2];

	// the glyph and hex views keep each digit's code at the same bits, and the mode picks the decode
	assign code = disp_word.hex[digit_sel];

	always_comb
	begin
		if (glyph_sel)
			a_to_g = seg_pkg::glyph_segments(code);
		else
			a_to_g = seg_pkg::hex_segments(code);
	end

	// the display is common anode, so the active digit has its anode pulled low
	always_comb
	begin
		an = '1;
		for (int k = 0; k < seg_pkg::NUM_DIGITS; k++)
		begin
			if ((digit_sel == 3'(k)) && digit_en[k])
				an[k] = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* seg_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module seg_display_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int DIV_BITS   = 17
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  logic                in_valid,
	input  logic [31:0]         in_data,
	input  seg_pkg::disp_mode_e in_mode,
	output logic                credit,
	output logic [6:0]          a_to_g,
	output logic [7:0]          an
);

	logic [2:0]          digit_sel;
	logic                frame_end;
	logic [7:0]          digit_en;
	seg_pkg::disp_word_u disp_word;
	seg_pkg::disp_mode_e disp_mode;

	value_receiver #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_receiver (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (in_data),
		.in_mode  (in_mode),
		.frame_end(frame_end),
		.credit   (credit),
		.disp_word(disp_word),
		.disp_mode(disp_mode)
	);

	scan_timer #(
		.DIV_BITS(DIV_BITS)
	) u_scan (
		.clk      (clk),
		.rst_n    (rst_n),
		.digit_sel(digit_sel),
		.frame_end(frame_end)
	);

	zero_blanker u_blank (
		.disp_word(disp_word),
		.disp_mode(disp_mode),
		.digit_en (digit_en)
	);

	segment_driver u_drive (
		.digit_sel(digit_sel),
		.disp_word(disp_word),
		.disp_mode(disp_mode),
		.digit_en (digit_en),
		.a_to_g   (a_to_g),
		.an       (an)
	);

endmodule

`default_nettype wire

/* tb_seg_display.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_seg_display;

	localparam int FIFO_DEPTH = 4;
	localparam int DIV_BITS   = 2;
	localparam int FRAME      = 8 << DIV_BITS;
	localparam int LIMIT      = 64 * FRAME + 256;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	logic [31:0]         in_data;
	seg_pkg::disp_mode_e in_mode;
	logic                credit;
	logic [6:0]          a_to_g;
	logic [7:0]          an;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;
	int     credits = FIFO_DEPTH;
	int     words_sent = 0;
	int     credit_pulses = 0;
	logic   allow_idle = 1'b0;

	logic [32:0]           to_send [$];
	logic [32:0]           model_q [$];
	logic [32:0]           send_item;
	logic [31:0]           cur_word;
	logic                  cur_mode;
	logic                  exp_credit;
	logic [DIV_BITS+2:0]   scan_cnt;

	seg_display_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.DIV_BITS  (DIV_BITS)
	) u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_valid(in_valid),
		.in_data (in_data),
		.in_mode (in_mode),
		.credit  (credit),
		.a_to_g  (a_to_g),
		.an      (an)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// lit segments in active-high order with bit 0 as segment a
	function automatic logic [6:0] segments_on(input logic glyph, input logic [3:0] code);
		logic [6:0] on;
		case ({glyph, code})
			5'h00: on = 7'h3f;
			5'h01: on = 7'h06;
			5'h02: on = 7'h5b;
			5'h03: on = 7'h4f;
			5'h04: on = 7'h66;
			5'h05: on = 7'h6d;
			5'h06: on = 7'h7d;
			5'h07: on = 7'h07;
			5'h08: on = 7'h7f;
			5'h09: on = 7'h6f;
			5'h0a: on = 7'h77;
			5'h0b: on = 7'h7c;
			5'h0c: on = 7'h39;
			5'h0d: on = 7'h5e;
			5'h0e: on = 7'h79;
			5'h0f: on = 7'h71;
			5'h11: on = 7'h74;
			5'h12: on = 7'h6d;
			5'h13: on = 7'h06;
			5'h14: on = 7'h76;
			5'h15: on = 7'h79;
			5'h16: on = 7'h38;
			5'h17: on = 7'h73;
			5'h18: on = 7'h50;
			5'h19: on = 7'h5c;
			5'h1a: on = 7'h54;
			5'h1b: on = 7'h1c;
			5'h1c: on = 7'h40;
			default: on = 7'h00;
		endcase
		return on;
	endfunction

	// returns the expected segments in the upper seven bits and the anodes below
	function automatic logic [14:0] expected_display(input logic [31:0] word, input logic mixed,
			input logic [2:0] idx);
		logic       glyph;
		logic       lit;
		logic [3:0] code;
		logic [7:0] an_exp;
		int         top;
		glyph  = mixed && (idx >= 3'd4);
		code   = word[idx*4 +: 4];
		top    = mixed ? 3 : 7;
		lit    = (idx == 3'd0) || glyph;
		for (int k = 0; k <= top; k++)
		begin
			if ((k >= idx) && (word[k*4 +: 4] != 4'h0))
				lit = 1'b1;
		end
		an_exp = 8'hff;
		if (lit)
			an_exp[idx] = 1'b0;
		return {~segments_on(glyph, code), an_exp};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic queue_word(input logic [31:0] data, input logic mixed);
		to_send.push_back({mixed, data});
	endtask

	task automatic wait_drained;
		while ((to_send.size() != 0) || (credits != FIFO_DEPTH))
			@(posedge clk);
	endtask

	// the producer spends one credit per valid cycle
	always @(negedge clk)
	begin
		in_valid = 1'b0;
		if (rst_n)
		begin
			if (credit)
			begin
				credits = credits + 1;
				if (credits > FIFO_DEPTH)
				begin
					errors++;
					$display("a credit came back for a word that was never sent");
				end
			end
			if ((to_send.size() > 0) && (credits > 0) && !(allow_idle && (($random(seed) & 3) == 0)))
			begin
				send_item = to_send.pop_front();
				in_data   = send_item[31:0];
				in_mode   = seg_pkg::disp_mode_e'(send_item[32]);
				in_valid  = 1'b1;
				credits   = credits - 1;
				words_sent++;
			end
		end
	end

	// the reference model of the FIFO and the scan is compared against the cycle that just ended
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scan_cnt   = '0;
			cur_word   = '0;
			cur_mode   = 1'b0;
			exp_credit = 1'b0;
			model_q.delete();
		end
		else
		begin
			check_value("a_to_g", a_to_g,
				expected_display(cur_word, cur_mode, scan_cnt[DIV_BITS+2:DIV_BITS]) >> 8);
			check_value("an", an, expected_display(cur_word, cur_mode,
				scan_cnt[DIV_BITS+2:DIV_BITS]) & 15'h00ff);
			check_value("credit", credit, exp_credit);
			if (credit)
				credit_pulses++;
			exp_credit = 1'b0;
			if ((&scan_cnt) && (model_q.size() > 0))
			begin
				{cur_mode, cur_word} = model_q.pop_front();
				exp_credit = 1'b1;
			end
			if (in_valid)
				model_q.push_back({in_mode, in_data});
			scan_cnt = scan_cnt + 1'b1;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout, the run did not finish within %0d cycles", LIMIT);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		seed     = 32'hdfb6;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		in_mode  = seg_pkg::mode_hex;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle display after reset
		repeat (40) @(posedge clk);

		queue_word(32'h0000_0000, 1'b0);
		queue_word(32'hffff_ffff, 1'b0);
		queue_word(32'h0000_0a50, 1'b0);
		queue_word(32'h4566_9007, 1'b1);
		queue_word(32'h0dfe_0000, 1'b1);
		queue_word(32'hc8ab_0001, 1'b1);
		wait_drained();

		// back-to-back burst that fills the FIFO
		for (int i = 0; i < FIFO_DEPTH; i++)
			queue_word(32'h1357_9bd0 + i * 32'h0101_0101, i[0]);
		wait_drained();

		allow_idle = 1'b1;
		for (int i = 0; i < 40; i++)
			queue_word($random(seed) >> (4 * ($random(seed) & 7)), $random(seed) & 1);
		wait_drained();
		repeat (FRAME) @(posedge clk);

		check_value("credit_pulses", credit_pulses, words_sent);
		check_value("credits", credits, FIFO_DEPTH);
		$display("checks %0d, errors %0d, words %0d", checks, errors, words_sent);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
seg_pkg.sv
value_receiver.sv
scan_timer.sv
zero_blanker.sv
segment_driver.sv
seg_display_top.sv
tb_seg_display.sv

/* Bender.yml */
package:
  name: seg_display

sources:
  - seg_pkg.sv
  - value_receiver.sv
  - scan_timer.sv
  - zero_blanker.sv
  - segment_driver.sv
  - seg_display_top.sv
  - target: test
    files:
      - tb_seg_display.sv
